// File: design/box_consts.svh
`ifndef BOX_CONSTS_SVH
`define BOX_CONSTS_SVH

// frame geometry.
`define BOX_COLS   15
`define BOX_ROWS   4

// sliding window length in pixels.
`define BOX_WINDOW 12

// datapath widths.
`define BOX_PIX_W  8
`define BOX_COL_W  10
`define BOX_ROW_W  4
`define BOX_SUM_W  12   // holds 15 pixels of 255.

`endif

// File: design/box_pkg.sv
`include "box_consts.svh"

package box_pkg;

  typedef logic [`BOX_PIX_W-1:0] pixel_t;
  typedef logic [`BOX_COL_W-1:0] col_t;
  typedef logic [`BOX_ROW_W-1:0] row_t;
  typedef logic [`BOX_SUM_W-1:0] sum_t;

  // three-bit binary encoding.
  typedef enum logic [2:0] {
    idle      = 3'd0,
    warm_up   = 3'd1,
    row_start = 3'd2,
    fill      = 3'd3,
    emit      = 3'd4,
    frame_end = 3'd5
  } seq_state_t;

  typedef struct packed {
    logic count_en;   // step the column counter.
    logic ld_en;      // restart both sums at column 0.
    logic sum_en;     // slide the window.
    logic cum_en;     // results valid this row.
    logic warm_en;
    logic reset_en;   // end of frame clear.
  } ctrl_t;

  typedef struct packed {
    row_t row;
    col_t col;
    sum_t window_sum;
    sum_t prefix_sum;
  } box_result_t;

endpackage

// File: design/frame_buffer.sv
`timescale 1ns/100ps
`include "box_consts.svh"

module frame_buffer (
  input  logic            clk,
  input  logic            wr_en,
  input  box_pkg::row_t   wr_row,
  input  box_pkg::col_t   wr_col,
  input  box_pkg::pixel_t wr_data,
  input  box_pkg::row_t   rd_row,
  input  box_pkg::col_t   rd_col,
  output box_pkg::pixel_t rd_data
);

  localparam int unsigned DEPTH  = `BOX_ROWS * `BOX_COLS;
  localparam int unsigned ADDR_W = $clog2(DEPTH);

  typedef logic [ADDR_W-1:0] addr_t;

  box_pkg::pixel_t mem [DEPTH];
  addr_t           wr_addr;
  addr_t           rd_addr;

  // row-major flat index.
  function automatic addr_t flat_addr(box_pkg::row_t row, box_pkg::col_t col);
    flat_addr = addr_t'(int'(row) * `BOX_COLS + int'(col));
  endfunction

  assign wr_addr = flat_addr(wr_row, wr_col);
  assign rd_addr = flat_addr(rd_row, rd_col);

  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

  assign rd_data = mem[rd_addr];   // same-cycle read.

endmodule

// File: design/box_sequencer.sv
`timescale 1ns/100ps
`include "box_consts.svh"

module box_sequencer #(
  parameter int COLS = `BOX_COLS
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           frame_loaded,
  input  logic           warm_done,
  input  box_pkg::col_t  col,
  input  logic           last_pos,
  output box_pkg::ctrl_t ctrl,
  output logic           emit_strobe,
  output logic           frame_done
);

  box_pkg::seq_state_t state;
  box_pkg::seq_state_t next_state;
  box_pkg::seq_state_t prev_state;   // tells row_start it came from emit.

  logic fill_done;
  logic row_done;

  assign fill_done = col > box_pkg::col_t'(`BOX_WINDOW - 1);
  assign row_done  = col > box_pkg::col_t'(COLS - 2);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= box_pkg::idle;
      prev_state <= box_pkg::idle;
    end else begin
      state      <= next_state;
      prev_state <= state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      box_pkg::idle:
        if (frame_loaded)
          next_state = box_pkg::warm_up;
      box_pkg::warm_up:
        if (warm_done)
          next_state = box_pkg::row_start;
      box_pkg::row_start:
        next_state = box_pkg::fill;
      box_pkg::fill:
        if (fill_done)
          next_state = box_pkg::emit;
      box_pkg::emit:
        if (last_pos)
          next_state = box_pkg::frame_end;
        else if (row_done)
          next_state = box_pkg::row_start;
      box_pkg::frame_end:
        next_state = box_pkg::idle;
      default:
        next_state = box_pkg::idle;
    endcase
  end

  always_comb begin
    ctrl        = '0;
    emit_strobe = 1'b0;
    frame_done  = 1'b0;
    case (state)
      box_pkg::warm_up:
        ctrl.warm_en = 1'b1;
      box_pkg::row_start: begin
        ctrl.ld_en    = 1'b1;
        ctrl.count_en = 1'b1;
        emit_strobe   = prev_state == box_pkg::emit;   // last column of previous row.
      end
      box_pkg::fill: begin
        ctrl.count_en = 1'b1;
        ctrl.sum_en   = 1'b1;
      end
      box_pkg::emit: begin
        ctrl.count_en = 1'b1;
        ctrl.sum_en   = 1'b1;
        ctrl.cum_en   = 1'b1;
        emit_strobe   = 1'b1;
      end
      box_pkg::frame_end: begin
        ctrl.reset_en = 1'b1;
        frame_done    = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: design/position_counters.sv
`timescale 1ns/100ps
`include "box_consts.svh"

module position_counters (
  input  logic           clk,
  input  logic           rst_n,
  input  box_pkg::ctrl_t ctrl,
  output logic           warm_done,
  output box_pkg::col_t  col,
  output box_pkg::row_t  rd_row,
  output box_pkg::col_t  rd_col,
  output logic           last_pos
);

  logic [1:0]    warm_cnt;
  box_pkg::row_t row;
  logic          last_col;
  logic          last_row;

  assign warm_done = warm_cnt > 2'd2;
  assign last_col  = col == box_pkg::col_t'(`BOX_COLS - 1);
  assign last_row  = row == box_pkg::row_t'(`BOX_ROWS - 1);
  assign last_pos  = last_col && last_row;

  always_ff @(posedge clk) begin
    if (!rst_n || ctrl.reset_en)
      warm_cnt <= '0;
    else if (ctrl.warm_en && !warm_done)
      warm_cnt <= warm_cnt + 2'd1;   // holds once done.
  end

  always_ff @(posedge clk) begin
    if (!rst_n || ctrl.reset_en)
      col <= '0;
    else if (ctrl.ld_en)
      col <= box_pkg::col_t'(1);   // column 0 read this cycle.
    else if (ctrl.count_en)
      col <= last_col ? '0 : col + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!rst_n || ctrl.reset_en)
      row <= '0;
    else if (ctrl.cum_en && last_col)
      row <= last_row ? '0 : row + 1'b1;   // wrap keeps the read in range.
  end

  assign rd_row = row;
  assign rd_col = col;

endmodule

// File: design/window_sum.sv
`timescale 1ns/100ps
`include "box_consts.svh"

module window_sum (
  input  logic            clk,
  input  logic            rst_n,
  input  box_pkg::ctrl_t  ctrl,
  input  box_pkg::pixel_t pixel,
  output box_pkg::sum_t   window_sum
);

  box_pkg::pixel_t taps [`BOX_WINDOW];   // taps[0] is the newest.
  box_pkg::sum_t   sum_q;
  box_pkg::sum_t   pix_ext;
  box_pkg::sum_t   old_ext;

  assign pix_ext = box_pkg::sum_t'(pixel);
  assign old_ext = box_pkg::sum_t'(taps[`BOX_WINDOW-1]);

  always_ff @(posedge clk) begin
    if (ctrl.ld_en) begin
      taps[0] <= pixel;
      for (int i = 1; i < `BOX_WINDOW; i++) begin
        taps[i] <= '0;   // drop the previous row.
      end
    end else if (ctrl.sum_en) begin
      taps[0] <= pixel;
      for (int i = 1; i < `BOX_WINDOW; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  // add the incoming pixel, subtract the one leaving the window.
  always_ff @(posedge clk) begin
    if (!rst_n)
      sum_q <= '0;
    else if (ctrl.ld_en)
      sum_q <= pix_ext;
    else if (ctrl.sum_en)
      sum_q <= sum_q + pix_ext - old_ext;
  end

  assign window_sum = sum_q;

endmodule

// File: design/row_prefix_sum.sv
`timescale 1ns/100ps
`include "box_consts.svh"

module row_prefix_sum (
  input  logic            clk,
  input  logic            rst_n,
  input  box_pkg::ctrl_t  ctrl,
  input  box_pkg::pixel_t pixel,
  output box_pkg::sum_t   prefix_sum
);

  box_pkg::sum_t acc;
  box_pkg::sum_t pix_ext;

  assign pix_ext = box_pkg::sum_t'(pixel);

  always_ff @(posedge clk) begin
    if (!rst_n)
      acc <= '0;
    else if (ctrl.ld_en)
      acc <= pix_ext;   // column 0 starts the row.
    else if (ctrl.count_en)
      acc <= acc + pix_ext;
  end

  assign prefix_sum = acc;

endmodule

// File: design/result_combiner.sv
`timescale 1ns/100ps
`include "box_consts.svh"

module result_combiner (
  input  logic                 clk,
  input  logic                 rst_n,
  input  box_pkg::row_t        rd_row,
  input  box_pkg::col_t        rd_col,
  input  box_pkg::sum_t        window_sum,
  input  box_pkg::sum_t        prefix_sum,
  input  logic                 emit_strobe,
  input  logic                 frame_done,
  output box_pkg::box_result_t result,
  output logic                 res_valid,
  output logic                 frame_done_out
);

  box_pkg::row_t row_q;   // position the sums describe.
  box_pkg::col_t col_q;
  logic          capture;

  assign capture = emit_strobe || frame_done;

  always_ff @(posedge clk) begin
    row_q <= rd_row;
    col_q <= rd_col;
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      result.row        <= row_q;
      result.col        <= col_q;
      result.window_sum <= window_sum;
      result.prefix_sum <= prefix_sum;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid      <= 1'b0;
      frame_done_out <= 1'b0;
    end else begin
      res_valid      <= capture;
      frame_done_out <= frame_done;   // lines up with the last result.
    end
  end

endmodule

// File: design/box_sum_top.sv
`timescale 1ns/100ps
`include "box_consts.svh"

module box_sum_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wr_en,
  input  box_pkg::row_t        wr_row,
  input  box_pkg::col_t        wr_col,
  input  box_pkg::pixel_t      wr_data,
  input  logic                 frame_loaded,
  output box_pkg::box_result_t result,
  output logic                 res_valid,
  output logic                 frame_done_out
);

  box_pkg::ctrl_t  ctrl;
  box_pkg::col_t   col;
  box_pkg::row_t   rd_row;
  box_pkg::col_t   rd_col;
  box_pkg::pixel_t rd_data;
  box_pkg::sum_t   win_sum;
  box_pkg::sum_t   pre_sum;
  logic            warm_done;
  logic            last_pos;
  logic            emit_strobe;
  logic            frame_done;

  frame_buffer i_frame_buffer (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_row  (wr_row),
    .wr_col  (wr_col),
    .wr_data (wr_data),
    .rd_row  (rd_row),
    .rd_col  (rd_col),
    .rd_data (rd_data)
  );

  position_counters i_position_counters (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .warm_done (warm_done),
    .col       (col),
    .rd_row    (rd_row),
    .rd_col    (rd_col),
    .last_pos  (last_pos)
  );

  box_sequencer #(.COLS(`BOX_COLS)) i_box_sequencer (
    .clk          (clk),
    .rst_n        (rst_n),
    .frame_loaded (frame_loaded),
    .warm_done    (warm_done),
    .col          (col),
    .last_pos     (last_pos),
    .ctrl         (ctrl),
    .emit_strobe  (emit_strobe),
    .frame_done   (frame_done)
  );

  window_sum i_window_sum (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .pixel      (rd_data),
    .window_sum (win_sum)
  );

  row_prefix_sum i_row_prefix_sum (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .pixel      (rd_data),
    .prefix_sum (pre_sum)
  );

  result_combiner i_result_combiner (
    .clk            (clk),
    .rst_n          (rst_n),
    .rd_row         (rd_row),
    .rd_col         (rd_col),
    .window_sum     (win_sum),
    .prefix_sum     (pre_sum),
    .emit_strobe    (emit_strobe),
    .frame_done     (frame_done),
    .result         (result),
    .res_valid      (res_valid),
    .frame_done_out (frame_done_out)
  );

endmodule

// File: sim/tb_box_sum.sv
`timescale 1ns/100ps
`include "box_consts.svh"

module tb_box_sum;

  localparam int CLK_PERIOD      = 10;
  localparam int FRAME_LIMIT     = 200;   // cycles allowed per frame.
  localparam int WATCHDOG_CYCLES = 4 * FRAME_LIMIT + 100;
  localparam int PER_FRAME       = `BOX_ROWS * (`BOX_COLS - `BOX_WINDOW);

  // model values kept at full width.
  typedef struct packed {
    int row;
    int col;
    int window_sum;
    int prefix_sum;
  } expected_t;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 wr_en;
  box_pkg::row_t        wr_row;
  box_pkg::col_t        wr_col;
  box_pkg::pixel_t      wr_data;
  logic                 frame_loaded;
  box_pkg::box_result_t result;
  logic                 res_valid;
  logic                 frame_done_out;

  box_pkg::pixel_t      frame [`BOX_ROWS][`BOX_COLS];   // model copy of the buffer.
  expected_t            expect_q [$];
  logic [31:0]          lcg_state = 32'h6f7d_c522;
  int                   frames_done = 0;
  int                   results_seen = 0;

  box_sum_top i_box_sum_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .wr_en          (wr_en),
    .wr_row         (wr_row),
    .wr_col         (wr_col),
    .wr_data        (wr_data),
    .frame_loaded   (frame_loaded),
    .result         (result),
    .res_valid      (res_valid),
    .frame_done_out (frame_done_out)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic end_with_failure();
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_error(input string what);
    $display("error at %0t: %s", $time, what);
    end_with_failure();
  endtask

  task automatic check_value(input int actual, input int expected, input string what);
    if (actual != expected) begin
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
      end_with_failure();
    end
  endtask

  // sum of pixels c-WINDOW+1 .. c of row r.
  function automatic int window_ref(input int r, input int c);
    int sum = 0;
    for (int k = c - `BOX_WINDOW + 1; k <= c; k++) begin
      sum += frame[r][k];
    end
    return sum;
  endfunction

  function automatic int prefix_ref(input int r, input int c);
    int sum = 0;
    for (int k = 0; k <= c; k++) begin
      sum += frame[r][k];
    end
    return sum;
  endfunction

  // row-major order over columns WINDOW .. COLS-1.
  task automatic queue_expected();
    expected_t item;
    for (int r = 0; r < `BOX_ROWS; r++) begin
      for (int c = `BOX_WINDOW; c < `BOX_COLS; c++) begin
        item.row        = r;
        item.col        = c;
        item.window_sum = window_ref(r, c);
        item.prefix_sum = prefix_ref(r, c);
        expect_q.push_back(item);
      end
    end
  endtask

  always @(negedge clk) begin : monitor
    expected_t want;
    if (rst_n === 1'b1) begin
      if (res_valid) begin
        if (expect_q.size() == 0)
          report_error("result arrived with nothing expected");
        want = expect_q.pop_front();
        check_value(result.row, want.row, "row tag");
        check_value(result.col, want.col, "column tag");
        check_value(result.window_sum, want.window_sum, "window sum");
        check_value(result.prefix_sum, want.prefix_sum, "prefix sum");
        results_seen++;
      end
      if (frame_done_out) begin
        frames_done++;
        check_value(res_valid, 1, "res_valid with frame_done_out");
        check_value(expect_q.size(), 0, "results pending at frame_done_out");
      end
    end
  end

  task automatic fill_random();
    for (int r = 0; r < `BOX_ROWS; r++) begin
      for (int c = 0; c < `BOX_COLS; c++) begin
        frame[r][c] = box_pkg::pixel_t'(lcg_next() >> 16);
      end
    end
  endtask

  task automatic fill_constant(input int value);
    for (int r = 0; r < `BOX_ROWS; r++) begin
      for (int c = 0; c < `BOX_COLS; c++) begin
        frame[r][c] = box_pkg::pixel_t'(value);
      end
    end
  endtask

  task automatic load_frame();
    for (int r = 0; r < `BOX_ROWS; r++) begin
      for (int c = 0; c < `BOX_COLS; c++) begin
        @(posedge clk);
        #1;
        wr_en   = 1'b1;
        wr_row  = box_pkg::row_t'(r);
        wr_col  = box_pkg::col_t'(c);
        wr_data = frame[r][c];
      end
    end
    @(posedge clk);
    #1;
    wr_en = 1'b0;
  endtask

  task automatic pulse_frame_loaded();
    @(posedge clk);
    #1;
    frame_loaded = 1'b1;
    @(posedge clk);
    #1;
    frame_loaded = 1'b0;
  endtask

  task automatic run_frame(input bit stray_pulse);
    int start_frames;
    int start_results;
    int waited;
    start_frames  = frames_done;
    start_results = results_seen;
    waited        = 0;
    queue_expected();
    pulse_frame_loaded();
    if (stray_pulse) begin
      repeat (10) @(posedge clk);
      pulse_frame_loaded();   // dropped while the sequencer is busy.
    end
    while (frames_done == start_frames) begin
      @(posedge clk);
      waited++;
      if (waited > FRAME_LIMIT)
        report_error("frame_done_out never arrived");
    end
    repeat (30) @(posedge clk);   // no further frame may start.
    check_value(frames_done - start_frames, 1, "frame_done_out pulses");
    check_value(results_seen - start_results, PER_FRAME, "results per frame");
  endtask

  task automatic idle_after_reset();
    repeat (20) begin
      @(negedge clk);
      check_value(res_valid, 0, "res_valid while idle");
      check_value(frame_done_out, 0, "frame_done_out while idle");
    end
  endtask

  task automatic random_frame_sums();
    fill_random();
    load_frame();
    run_frame(1'b0);
  endtask

  // 12 x 255 and 15 x 255 both fit in the sum width.
  task automatic saturated_frame_sums();
    fill_constant(255);
    load_frame();
    run_frame(1'b0);
  endtask

  task automatic back_to_back_frames();
    fill_random();
    load_frame();
    run_frame(1'b0);
    fill_random();
    load_frame();
    run_frame(1'b1);
  endtask

  initial begin
    rst_n        = 1'b0;
    wr_en        = 1'b0;
    wr_row       = '0;
    wr_col       = '0;
    wr_data      = '0;
    frame_loaded = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    idle_after_reset();
    random_frame_sums();
    saturated_frame_sums();
    back_to_back_frames();

    if (frames_done == 4 && expect_q.size() == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      report_error("wrong frame count or results left over at end of run");
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    report_error("watchdog expired before the tests finished");
  end

endmodule

// File: sim.f
+incdir+design
design/box_pkg.sv
design/frame_buffer.sv
design/box_sequencer.sv
design/position_counters.sv
design/window_sum.sv
design/row_prefix_sum.sv
design/result_combiner.sv
design/box_sum_top.sv
sim/tb_box_sum.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_box_sum
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
